// File: rtl/mfrsd_pkg.sv
package mfrsd_pkg;

   // external memory byte address, 128 MB space
   typedef logic [26:0] mem_addr_t;

   // z80 side
   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  cpu_data_t;

   // subslot number behind the expander
   typedef logic [1:0]  sub_slot_t;

   // ram mapper segment or flash bank number
   typedef logic [7:0]  segment_t;

   // cpu bus as seen by the cartridge, 28 bits
   typedef struct packed {
      cpu_addr_t addr;
      cpu_data_t dout;
      logic      rd;
      logic      wr;
      logic      iorq;
      logic      m1;
   } cpu_bus_t;

   // memory request towards the external memory, 28 bits
   typedef struct packed {
      mem_addr_t addr;
      logic      unmapped;
   } mem_req_t;

   // flash rom region inside the subslot area
   localparam mem_addr_t SD_ROM_OFFSET = 27'h700000;

   // subslot assignment of the cartridge
   localparam sub_slot_t CFG_SUBSLOT = 2'd0;
   localparam sub_slot_t SCC_SUBSLOT = 2'd1;
   localparam sub_slot_t RAM_SUBSLOT = 2'd2;
   localparam sub_slot_t SD_SUBSLOT  = 2'd3;

endpackage

// File: rtl/mfrsd_config.sv
`timescale 1ns/1ps

module mfrsd_config (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 cs,
   input  mfrsd_pkg::sub_slot_t sub_slot,
   input  mfrsd_pkg::cpu_bus_t  bus,
   input  logic                 base_wr,
   input  logic                 base_slot,
   input  mfrsd_pkg::mem_addr_t base_value,
   output mfrsd_pkg::mem_addr_t base_ram [2],
   output mfrsd_pkg::cpu_data_t config_reg,
   output logic [3:0]           mapper_mask,
   output logic [9:0]           offset_reg,
   output mfrsd_pkg::cpu_data_t mapper_reg
);

   import mfrsd_pkg::*;

   // register addresses in the config subslot
   localparam cpu_addr_t CONFIG_ADDR    = 16'h7FFC;
   localparam cpu_addr_t OFFSET_LO_ADDR = 16'h7FFD;
   localparam cpu_addr_t OFFSET_HI_ADDR = 16'h7FFE;
   localparam cpu_addr_t MAPPER_ADDR    = 16'h7FFF;

   logic cfg_wr;

   assign cfg_wr = cs & bus.wr;

   // subslot base addresses, loaded by the host side
   always_ff @(posedge clk) begin
      if (reset) begin
         base_ram <= '{default: '0};
      end else if (base_wr) begin
         base_ram[base_slot] <= base_value;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         config_reg  <= 8'h03;
         mapper_mask <= 4'b1111;
         offset_reg  <= '0;
         mapper_reg  <= '0;
      end else if (cfg_wr) begin
         case (bus.addr)
            CONFIG_ADDR: begin
               // bit 7 locks the config register until reset
               if (!config_reg[7]) begin
                  config_reg            <= bus.dout;
                  mapper_mask[sub_slot] <= ~bus.dout[2];
               end
            end
            OFFSET_LO_ADDR: begin
               if (!mapper_reg[1]) begin
                  offset_reg[7:0] <= bus.dout;
               end
            end
            OFFSET_HI_ADDR: begin
               if (!mapper_reg[1]) begin
                  offset_reg[9:8] <= bus.dout[1:0];
               end
            end
            MAPPER_ADDR: begin
               // mapper reg bit 2 freezes itself
               if (!mapper_reg[2]) begin
                  mapper_reg <= bus.dout;
               end
            end
            default: begin
            end
         endcase
      end
   end

   // a locked config register must survive a write attempt
   property locked_config_holds;
      @(posedge clk) disable iff (reset)
         (cfg_wr && bus.addr == CONFIG_ADDR && config_reg[7]) |=> $stable(config_reg);
   endproperty

   assert property (locked_config_holds)
      else $error("config_reg changed while locked");

endmodule

// File: rtl/msx2_ram_mapper.sv
`timescale 1ns/1ps

module msx2_ram_mapper #(
   parameter int RAM_SEGMENTS = 32
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 cs,
   input  mfrsd_pkg::cpu_bus_t  bus,
   input  mfrsd_pkg::mem_addr_t base,
   output mfrsd_pkg::cpu_data_t dout,
   output logic                 io_hit,
   output mfrsd_pkg::mem_req_t  mem
);

   import mfrsd_pkg::*;

   // valid segment bits, RAM_SEGMENTS is a power of two
   localparam segment_t SEG_MASK = segment_t'(RAM_SEGMENTS - 1);

   segment_t  seg [4];
   segment_t  page_seg;
   mem_addr_t ram_addr;
   logic      io_sel;

   // ports FC-FF, interrupt acknowledge excluded
   assign io_sel = bus.iorq & ~bus.m1 & (bus.addr[7:2] == 6'b111111);
   assign io_hit = io_sel & bus.rd;

   always_ff @(posedge clk) begin
      if (reset) begin
         seg <= '{8'd3, 8'd2, 8'd1, 8'd0};
      end else if (io_sel & bus.wr) begin
         seg[bus.addr[1:0]] <= bus.dout & SEG_MASK;
      end
   end

   // unused high bits read back as ones
   assign dout = io_hit ? (seg[bus.addr[1:0]] | ~SEG_MASK) : 8'hFF;

   // 16 KB segment per page
   assign page_seg = seg[bus.addr[15:14]];
   assign ram_addr = base + mem_addr_t'({page_seg, 14'd0}) + mem_addr_t'(bus.addr[13:0]);

   // address bus stays quiet unless the ram subslot is selected
   assign mem.addr     = cs ? ram_addr : '0;
   assign mem.unmapped = 1'b0;

   for (genvar i = 0; i < 4; i++) begin : g_seg_check
      assert property (@(posedge clk) disable iff (reset) seg[i] < RAM_SEGMENTS)
         else $error("segment %0d out of range", i);
   end

endmodule

// File: rtl/mfrsd_sd_rom.sv
`timescale 1ns/1ps

module mfrsd_sd_rom (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 cs,
   input  mfrsd_pkg::cpu_bus_t  bus,
   input  mfrsd_pkg::mem_addr_t base,
   input  mfrsd_pkg::cpu_data_t sd_din,
   output mfrsd_pkg::cpu_data_t dout,
   output mfrsd_pkg::mem_req_t  mem,
   output logic                 sd_rx,
   output logic                 sd_tx
);

   import mfrsd_pkg::*;

   segment_t   bank [4];
   logic [1:0] page;
   logic       flash_area;
   logic       sd_window;
   logic       sd_read;
   logic       sd_data_addr;
   logic       sd_sel_addr;
   logic       select_sd;
   logic       old_rd;
   logic       old_wr;

   // bank registers at 6000-7FFF, two address bits pick the bank
   always_ff @(posedge clk) begin
      if (reset) begin
         bank <= '{8'd0, 8'd1, 8'd0, 8'd0};
      end else if (cs & bus.wr & (bus.addr[15:13] == 3'b011)) begin
         bank[bus.addr[12:11]] <= bus.dout;
      end
   end

   // 4000-BFFF, four 8 KB pages
   assign flash_area = (bus.addr[15:14] == 2'b01) | (bus.addr[15:14] == 2'b10);
   assign page       = 2'(bus.addr[15:13] - 3'd2);

   assign mem.addr = base + SD_ROM_OFFSET
                   + mem_addr_t'({bank[page][6:0], 13'd0})
                   + mem_addr_t'(bus.addr[12:0]);

   // sd window 4000-5FFF, enabled through bank 0 bits 7-6
   assign sd_window    = cs & (bank[0][7:6] == 2'b01) & (bus.addr[15:13] == 3'b010);
   assign sd_read      = sd_window & bus.rd;
   assign sd_data_addr = ~bus.addr[12];
   // 5800 and above
   assign sd_sel_addr  = bus.addr[15:11] == 5'b01011;

   assign mem.unmapped = cs & (~flash_area | sd_read);

   assign dout = (sd_read & sd_data_addr) ? sd_din : 8'hFF;

   always_ff @(posedge clk) begin
      if (reset) begin
         select_sd <= 1'b0;
      end else if (sd_window & bus.wr & sd_sel_addr) begin
         select_sd <= bus.dout[0];
      end
   end

   // strobes fire once per access, on the rising edge of rd or wr
   always_ff @(posedge clk) begin
      if (reset) begin
         old_rd <= 1'b0;
         old_wr <= 1'b0;
         sd_rx  <= 1'b0;
         sd_tx  <= 1'b0;
      end else begin
         old_rd <= bus.rd;
         old_wr <= bus.wr;
         sd_rx  <= sd_read & ~old_rd & sd_data_addr & ~select_sd;
         sd_tx  <= sd_window & bus.wr & ~old_wr & ~sd_sel_addr
                   & sd_data_addr & ~select_sd;
      end
   end

   // rd and wr never overlap on the z80 bus
   assert property (@(posedge clk) disable iff (reset) !(sd_rx && sd_tx))
      else $error("sd_rx and sd_tx high together");

endmodule

// File: rtl/mfrsd_cartridge.sv
`timescale 1ns/1ps

module mfrsd_cartridge #(
   parameter int RAM_SEGMENTS = 32
) (
   input  logic                 clk,
   input  logic                 reset,
   input  mfrsd_pkg::cpu_bus_t  bus,
   input  logic                 slot_cs,
   input  mfrsd_pkg::sub_slot_t sub_slot,
   input  logic                 base_wr,
   input  logic                 base_slot,
   input  mfrsd_pkg::mem_addr_t base_value,
   input  mfrsd_pkg::cpu_data_t sd_din,
   output mfrsd_pkg::mem_req_t  mem,
   output mfrsd_pkg::cpu_data_t dout,
   output logic                 sd_rx,
   output logic                 sd_tx,
   output mfrsd_pkg::cpu_data_t config_reg,
   output logic [3:0]           mapper_mask
);

   import mfrsd_pkg::*;

   // config subslot never reaches external memory
   localparam mem_req_t CFG_MEM = '{addr: '0, unmapped: 1'b1};

   mem_addr_t base_ram [2];
   mem_req_t  ram_mem;
   mem_req_t  sd_mem;
   cpu_data_t ram_dout;
   cpu_data_t sd_dout;
   logic      ram_io_hit;
   logic      mem_cs;
   logic      cfg_cs;
   logic      ram_cs;
   logic      sd_cs;

   // memory cycles only, i/o goes straight to the ram mapper
   assign mem_cs = slot_cs & ~bus.iorq;
   assign cfg_cs = mem_cs & (sub_slot == CFG_SUBSLOT);
   assign ram_cs = mem_cs & (sub_slot == RAM_SUBSLOT);
   assign sd_cs  = mem_cs & (sub_slot == SD_SUBSLOT);

   mfrsd_config u_config (
      .clk        (clk),
      .reset      (reset),
      .cs         (cfg_cs),
      .sub_slot   (sub_slot),
      .bus        (bus),
      .base_wr    (base_wr),
      .base_slot  (base_slot),
      .base_value (base_value),
      .base_ram   (base_ram),
      .config_reg (config_reg),
      .mapper_mask(mapper_mask),
      .offset_reg (),
      .mapper_reg ()
   );

   msx2_ram_mapper #(
      .RAM_SEGMENTS(RAM_SEGMENTS)
   ) u_ram_mapper (
      .clk   (clk),
      .reset (reset),
      .cs    (ram_cs),
      .bus   (bus),
      .base  (base_ram[0]),
      .dout  (ram_dout),
      .io_hit(ram_io_hit),
      .mem   (ram_mem)
   );

   mfrsd_sd_rom u_sd_rom (
      .clk   (clk),
      .reset (reset),
      .cs    (sd_cs),
      .bus   (bus),
      .base  (base_ram[1]),
      .sd_din(sd_din),
      .dout  (sd_dout),
      .mem   (sd_mem),
      .sd_rx (sd_rx),
      .sd_tx (sd_tx)
   );

   always_comb begin
      case (sub_slot)
         CFG_SUBSLOT, SCC_SUBSLOT: mem = CFG_MEM;
         RAM_SUBSLOT:              mem = ram_mem;
         default:                  mem = sd_mem;
      endcase
   end

   // mapper port readback wins, then sd data, else open bus
   always_comb begin
      if (ram_io_hit) begin
         dout = ram_dout;
      end else if (sd_cs & bus.rd) begin
         dout = sd_dout;
      end else begin
         dout = 8'hFF;
      end
   end

endmodule

// File: test/tb_mfrsd.sv
`timescale 1ns/1ps

module tb_mfrsd;

   import mfrsd_pkg::*;

   localparam int RAM_SEGMENTS = 32;
   localparam int NUM_TXN      = 3000;
   // at most 4 cycles of 20 ns per transaction plus a margin
   localparam int TIMEOUT_NS   = (NUM_TXN + 20) * 4 * 20 + 2000;
   localparam segment_t SEG_MASK = segment_t'(RAM_SEGMENTS - 1);

   logic       clk;
   logic       reset;
   cpu_bus_t   bus;
   logic       slot_cs;
   sub_slot_t  sub_slot;
   logic       base_wr;
   logic       base_slot;
   mem_addr_t  base_value;
   cpu_data_t  sd_din;
   mem_req_t   mem;
   cpu_data_t  dout;
   logic       sd_rx;
   logic       sd_tx;
   cpu_data_t  config_reg;
   logic [3:0] mapper_mask;

   // reference model state
   mem_addr_t  m_base [2];
   segment_t   m_seg [4];
   segment_t   m_bank [4];
   cpu_data_t  m_cfg;
   logic [3:0] m_mask;
   logic       m_sel_sd;
   integer     seed;

   mfrsd_cartridge #(
      .RAM_SEGMENTS(RAM_SEGMENTS)
   ) dut0 (
      .clk        (clk),
      .reset      (reset),
      .bus        (bus),
      .slot_cs    (slot_cs),
      .sub_slot   (sub_slot),
      .base_wr    (base_wr),
      .base_slot  (base_slot),
      .base_value (base_value),
      .sd_din     (sd_din),
      .mem        (mem),
      .dout       (dout),
      .sd_rx      (sd_rx),
      .sd_tx      (sd_tx),
      .config_reg (config_reg),
      .mapper_mask(mapper_mask)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
         $display("Result: FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   function automatic cpu_bus_t make_bus(input cpu_addr_t a, input cpu_data_t d,
                                         input logic rd, input logic wr, input logic iorq);
      cpu_bus_t b;
      b = '0;
      b.addr = a;
      b.dout = d;
      b.rd   = rd;
      b.wr   = wr;
      b.iorq = iorq;
      return b;
   endfunction

   // ports FC-FF outside interrupt acknowledge
   function automatic logic io_port_hit(input cpu_bus_t b);
      return b.iorq && !b.m1 && b.addr[7:0] >= 8'hFC;
   endfunction

   function automatic logic sd_window_hit(input cpu_bus_t b, input logic cs_v,
                                          input sub_slot_t ss);
      return cs_v && !b.iorq && ss == SD_SUBSLOT && m_bank[0][7:6] == 2'b01
             && b.addr >= 16'h4000 && b.addr < 16'h6000;
   endfunction

   task automatic load_base(input logic slot, input mem_addr_t value);
      @(posedge clk);
      base_wr    <= 1'b1;
      base_slot  <= slot;
      base_value <= value;
      @(posedge clk);
      base_wr    <= 1'b0;
      m_base[slot] = value;
   endtask

   // one active and one idle cycle with checks in both
   task automatic run_txn(input cpu_bus_t b, input logic cs_v, input sub_slot_t ss);
      mem_req_t  exp_mem;
      cpu_data_t exp_dout;
      cpu_data_t din_v;
      logic      mem_sel;
      logic      win;
      logic      check_addr;
      logic      exp_rx;
      logic      exp_tx;
      int        page;
      din_v      = 8'($random(seed));
      mem_sel    = cs_v && !b.iorq;
      win        = sd_window_hit(b, cs_v, ss);
      exp_mem    = '0;
      check_addr = mem_sel && ss == RAM_SUBSLOT;
      if (ss == CFG_SUBSLOT || ss == SCC_SUBSLOT) begin
         exp_mem.unmapped = 1'b1;
      end else if (ss == SD_SUBSLOT && mem_sel) begin
         exp_mem.unmapped = b.addr < 16'h4000 || b.addr >= 16'hC000 || (win && b.rd);
         check_addr = !exp_mem.unmapped;
      end
      if (ss == RAM_SUBSLOT) begin
         exp_mem.addr = m_base[0] + mem_addr_t'(m_seg[b.addr[15:14]]) * 27'h4000
                        + mem_addr_t'(b.addr[13:0]);
      end else if (check_addr) begin
         page = (int'(b.addr) - 'h4000) / 'h2000;
         exp_mem.addr = m_base[1] + SD_ROM_OFFSET + mem_addr_t'(m_bank[page][6:0]) * 27'h2000
                        + mem_addr_t'(b.addr[12:0]);
      end
      if (io_port_hit(b) && b.rd) begin
         exp_dout = m_seg[b.addr[1:0]] | ~SEG_MASK;
      end else if (win && b.rd && !b.addr[12]) begin
         exp_dout = din_v;
      end else begin
         exp_dout = 8'hFF;
      end
      exp_rx = win && b.rd && !b.addr[12] && !m_sel_sd;
      exp_tx = win && b.wr && !b.addr[12] && !m_sel_sd;

      @(posedge clk);
      bus      <= b;
      slot_cs  <= cs_v;
      sub_slot <= ss;
      sd_din   <= din_v;
      @(negedge clk);
      compare_value("mem.unmapped", mem.unmapped, exp_mem.unmapped);
      if (check_addr) begin
         compare_value("mem.addr", mem.addr, exp_mem.addr);
      end
      compare_value("dout", dout, exp_dout);
      compare_value("sd_rx", sd_rx, 1'b0);
      compare_value("sd_tx", sd_tx, 1'b0);

      @(posedge clk);
      bus     <= '0;
      slot_cs <= 1'b0;
      // register updates at the edge that sampled the access
      if (b.wr) begin
         if (mem_sel && ss == CFG_SUBSLOT && b.addr == 16'h7FFC && !m_cfg[7]) begin
            m_cfg      = b.dout;
            m_mask[ss] = !b.dout[2];
         end
         if (io_port_hit(b)) begin
            m_seg[b.addr[1:0]] = b.dout & SEG_MASK;
         end
         if (win && b.addr >= 16'h5800) begin
            m_sel_sd = b.dout[0];
         end
         if (mem_sel && ss == SD_SUBSLOT && b.addr >= 16'h6000 && b.addr < 16'h8000) begin
            m_bank[b.addr[12:11]] = b.dout;
         end
      end
      @(negedge clk);
      compare_value("sd_rx", sd_rx, exp_rx);
      compare_value("sd_tx", sd_tx, exp_tx);
      compare_value("config_reg", config_reg, m_cfg);
      compare_value("mapper_mask", mapper_mask, m_mask);
   endtask

   task automatic random_txn();
      cpu_bus_t  b;
      logic      cs_v;
      sub_slot_t ss;
      int        kind;
      b      = '0;
      b.addr = 16'($random(seed));
      b.dout = 8'($random(seed));
      cs_v   = 1'b1;
      ss     = RAM_SUBSLOT;
      kind   = int'($unsigned($random(seed)) % 9);
      case (kind)
         0: begin
            ss     = CFG_SUBSLOT;
            b.addr = {14'h1FFF, 2'($random(seed))};
            b.wr   = 1'b1;
            // the lock bit only now and then
            if (5'($random(seed)) != 5'd0) begin
               b.dout[7] = 1'b0;
            end
         end
         1, 2: begin
            ss     = sub_slot_t'($random(seed));
            cs_v   = 1'($random(seed));
            b.addr = {8'($random(seed)), 6'h3F, 2'($random(seed))};
            b.iorq = 1'b1;
            b.wr   = kind == 1;
            b.rd   = kind == 2;
         end
         3: begin
            b.rd = 1'b1;
         end
         4: begin
            ss     = SD_SUBSLOT;
            b.addr = {3'b011, 13'($random(seed))};
            b.wr   = 1'b1;
            if (b.addr[12:11] == 2'd0 && 1'($random(seed))) begin
               b.dout = {2'b01, b.dout[5:0]};
            end
         end
         5: begin
            ss   = SD_SUBSLOT;
            b.rd = 1'b1;
            if (1'($random(seed))) begin
               b.addr[15:13] = 3'b010;
            end
         end
         6: begin
            ss            = SD_SUBSLOT;
            b.wr          = 1'b1;
            b.addr[15:13] = 3'b010;
            if (b.addr >= 16'h5800) begin
               b.dout[0] = 2'($random(seed)) == 2'd0;
            end
         end
         7: begin
            load_base(1'($random(seed)), 27'($random(seed)));
            return;
         end
         default: begin
            ss     = sub_slot_t'($random(seed));
            cs_v   = 1'($random(seed));
            b.iorq = 1'($random(seed));
            b.m1   = 1'($random(seed));
            b.rd   = 1'($random(seed));
            b.wr   = !b.rd;
         end
      endcase
      run_txn(b, cs_v, ss);
   endtask

   initial begin
      seed       = 16;
      reset      = 1'b1;
      bus        = '0;
      slot_cs    = 1'b0;
      sub_slot   = '0;
      base_wr    = 1'b0;
      base_slot  = 1'b0;
      base_value = '0;
      sd_din     = '0;
      m_base     = '{default: '0};
      m_seg      = '{8'd3, 8'd2, 8'd1, 8'd0};
      m_bank     = '{8'd0, 8'd1, 8'd0, 8'd0};
      m_cfg      = 8'h03;
      m_mask     = 4'b1111;
      m_sel_sd   = 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      compare_value("config_reg", config_reg, 8'h03);
      compare_value("mapper_mask", mapper_mask, 4'b1111);
      compare_value("sd_rx", sd_rx, 1'b0);
      compare_value("sd_tx", sd_tx, 1'b0);

      // segment readback straight out of reset
      for (int i = 0; i < 4; i++) begin
         run_txn(make_bus(16'(16'h00FC + i), 8'h00, 1'b1, 1'b0, 1'b1), 1'b1, RAM_SUBSLOT);
      end
      // reset bases and banks seen through memory reads
      run_txn(make_bus(16'h8123, 8'h00, 1'b1, 1'b0, 1'b0), 1'b1, RAM_SUBSLOT);
      run_txn(make_bus(16'h6123, 8'h00, 1'b1, 1'b0, 1'b0), 1'b1, SD_SUBSLOT);
      load_base(1'b0, 27'h0123456);
      load_base(1'b1, 27'h0200000);

      // sd window on and strobes until select_sd suppresses them
      run_txn(make_bus(16'h6000, 8'h40, 1'b0, 1'b1, 1'b0), 1'b1, SD_SUBSLOT);
      run_txn(make_bus(16'h4000, 8'h00, 1'b1, 1'b0, 1'b0), 1'b1, SD_SUBSLOT);
      run_txn(make_bus(16'h4100, 8'hA5, 1'b0, 1'b1, 1'b0), 1'b1, SD_SUBSLOT);
      run_txn(make_bus(16'h5800, 8'h01, 1'b0, 1'b1, 1'b0), 1'b1, SD_SUBSLOT);
      run_txn(make_bus(16'h4000, 8'h00, 1'b1, 1'b0, 1'b0), 1'b1, SD_SUBSLOT);
      run_txn(make_bus(16'h4200, 8'h5A, 1'b0, 1'b1, 1'b0), 1'b1, SD_SUBSLOT);
      run_txn(make_bus(16'h5800, 8'h00, 1'b0, 1'b1, 1'b0), 1'b1, SD_SUBSLOT);
      run_txn(make_bus(16'h6000, 8'h00, 1'b0, 1'b1, 1'b0), 1'b1, SD_SUBSLOT);

      repeat (NUM_TXN) begin
         random_txn();
      end

      // lock bit set and then a write that must be ignored
      run_txn(make_bus(16'h7FFC, 8'h84, 1'b0, 1'b1, 1'b0), 1'b1, CFG_SUBSLOT);
      run_txn(make_bus(16'h7FFC, 8'h03, 1'b0, 1'b1, 1'b0), 1'b1, CFG_SUBSLOT);

      $display("Result: PASSED");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("simulation timed out after %0d ns", TIMEOUT_NS);
      $display("Result: FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: project.f
rtl/mfrsd_pkg.sv
rtl/mfrsd_config.sv
rtl/msx2_ram_mapper.sv
rtl/mfrsd_sd_rom.sv
rtl/mfrsd_cartridge.sv
test/tb_mfrsd.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_mfrsd -f project.f -o sim_tb_mfrsd
./obj_dir/sim_tb_mfrsd
